// ==== logic/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  typedef enum logic [6:0] {
    op_load    = 7'b00_000_11,
    op_store   = 7'b01_000_11,
    op_branch  = 7'b11_000_11,
    op_jalr    = 7'b11_001_11,
    op_jal     = 7'b11_011_11,
    op_reg_imm = 7'b00_100_11,
    op_reg_reg = 7'b01_100_11,
    op_environ = 7'b11_100_11,
    op_auipc   = 7'b00_101_11,
    op_lui     = 7'b01_101_11
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one instruction word, six ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_u;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       src_b_imm;
    logic       src_a_pc;
    logic       reg_we;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_halt;
    logic [1:0] mem_size;
    // zero-extend on loads, inverted condition on branches
    logic       load_unsigned;
  } ctrl_t;

  typedef enum logic [1:0] {
    ph_fetch,
    ph_exec,
    ph_load
  } phase_e;

endpackage

// ==== logic/dmem_if.sv ====
interface dmem_if;
  import rv_pkg::*;

  // word index, not a byte address
  word_t      addr;
  word_t      wdata;
  logic [3:0] be;
  logic       re;
  word_t      rdata;

  modport lsu (
    output addr, wdata, be, re,
    input  rdata
  );

  modport ram (
    input  addr, wdata, be, re,
    output rdata
  );
endinterface

// ==== logic/reg_file.sv ====
module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  logic             we,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [32];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 keeps its reset value for good
  x0_zero_a: assert property (@(posedge clk) disable iff (rst)
    rs1 == '0 |-> rs1_data == '0);
endmodule

// ==== logic/fetch_seq.sv ====
module fetch_seq #(
  parameter int imem_words = 256
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           prog_we,
  input  rv_pkg::word_t  prog_addr,
  input  rv_pkg::word_t  prog_data,
  input  rv_pkg::word_t  next_pc,
  input  logic           is_load,
  input  logic           is_halt,
  output rv_pkg::word_t  pc,
  output rv_pkg::insn_u  insn,
  output rv_pkg::phase_e phase,
  output logic           retire,
  output logic           halt
);
  import rv_pkg::*;

  localparam int iaw = $clog2(imem_words);

  word_t imem [imem_words];

  // program load port and the fetch read share one array
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr[iaw-1:0]] <= prog_data;
    end
    if (phase == ph_fetch) begin
      insn <= imem[pc[iaw+1:2]];
    end
  end

  assign retire = (phase == ph_exec && !is_load) || phase == ph_load;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= '0;
      phase <= ph_fetch;
      halt  <= 1'b0;
    end else begin
      case (phase)
        ph_fetch: begin
          // a halted core parks here
          if (!halt) begin
            phase <= ph_exec;
          end
        end
        ph_exec: begin
          if (is_load) begin
            phase <= ph_load;
          end else begin
            pc    <= next_pc;
            phase <= ph_fetch;
            if (is_halt) begin
              halt <= 1'b1;
            end
          end
        end
        ph_load: begin
          pc    <= next_pc;
          phase <= ph_fetch;
        end
        default: phase <= ph_fetch;
      endcase
    end
  end

  pc_aligned_a: assert property (@(posedge clk) disable iff (rst)
    retire |-> next_pc[1:0] == 2'b00);

  // nothing retires once ecall has gone through
  halt_quiet_a: assert property (@(posedge clk) disable iff (rst)
    halt |-> !retire);
endmodule

// ==== logic/decoder.sv ====
module decoder (
  input  rv_pkg::insn_u    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output rv_pkg::ctrl_t    ctrl
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       imm_ok;
  logic       reg_ok;

  function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode = insn.r_fmt.opcode;
  assign funct3 = insn.r_fmt.funct3;
  assign funct7 = insn.r_fmt.funct7;
  assign rs1    = insn.r_fmt.rs1;
  assign rs2    = insn.r_fmt.rs2;
  assign rd     = insn.r_fmt.rd;

  // only the shifts put anything in the upper immediate bits
  assign imm_ok = (funct3 == 3'b001) ? funct7 == 7'd0 :
                  (funct3 == 3'b101) ? (funct7 == 7'd0 || funct7 == 7'b0100000) : 1'b1;
  assign reg_ok = funct7 == 7'd0 ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    case (opcode)
      op_load, op_jalr, op_reg_imm: imm = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
      op_store: imm = {{20{insn.s_fmt.imm_hi[6]}}, insn.s_fmt.imm_hi, insn.s_fmt.imm_lo};
      op_branch: imm = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                        insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
      op_lui, op_auipc: imm = {insn.u_fmt.imm, 12'b0};
      op_jal: imm = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                     insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};
      default: imm = '0;
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (opcode)
      op_lui: begin
        ctrl.alu_op    = alu_pass_b;
        ctrl.src_b_imm = 1'b1;
        ctrl.reg_we    = 1'b1;
      end
      op_auipc: begin
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.reg_we    = 1'b1;
      end
      op_jal: begin
        ctrl.is_jal = 1'b1;
        ctrl.reg_we = 1'b1;
      end
      op_jalr: begin
        ctrl.is_jalr = funct3 == 3'b000;
        ctrl.reg_we  = funct3 == 3'b000;
      end
      op_branch: begin
        // eq/ne by subtraction, the rest by set-less-than
        if (funct3[2:1] != 2'b01) begin
          ctrl.is_branch     = 1'b1;
          ctrl.alu_op        = !funct3[2] ? alu_sub : (funct3[1] ? alu_sltu : alu_slt);
          ctrl.load_unsigned = funct3[0];
        end
      end
      op_load: begin
        if (funct3[1:0] != 2'b11 && funct3 != 3'b110) begin
          ctrl.is_load       = 1'b1;
          ctrl.reg_we        = 1'b1;
          ctrl.mem_size      = funct3[1:0];
          ctrl.load_unsigned = funct3[2];
        end
      end
      op_store: begin
        if (!funct3[2] && funct3[1:0] != 2'b11) begin
          ctrl.is_store = 1'b1;
          ctrl.mem_size = funct3[1:0];
        end
      end
      op_reg_imm: begin
        if (imm_ok) begin
          ctrl.alu_op    = alu_of(funct3, funct7[5] && funct3 == 3'b101);
          ctrl.src_b_imm = 1'b1;
          ctrl.reg_we    = 1'b1;
        end
      end
      op_reg_reg: begin
        if (reg_ok) begin
          ctrl.alu_op = alu_of(funct3, funct7[5]);
          ctrl.reg_we = 1'b1;
        end
      end
      op_environ: begin
        // ecall is the all-zero environment word
        ctrl.is_halt = insn.i_fmt.imm == '0 && rs1 == '0 && funct3 == '0 && rd == '0;
      end
      default: ctrl = '0;
    endcase
  end
endmodule

// ==== logic/exec_unit.sv ====
module exec_unit (
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  input  rv_pkg::ctrl_t ctrl,
  output rv_pkg::word_t result,
  output rv_pkg::word_t next_pc,
  output rv_pkg::word_t mem_addr
);
  import rv_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_out;
  word_t pc_plus4;
  logic  cond;
  logic  taken;

  assign op_a = ctrl.src_a_pc ? pc : rs1_data;
  assign op_b = ctrl.src_b_imm ? imm : rs2_data;

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    alu_out = op_a + op_b;
      alu_sub:    alu_out = op_a - op_b;
      alu_sll:    alu_out = op_a << op_b[4:0];
      alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_out = op_a ^ op_b;
      alu_srl:    alu_out = op_a >> op_b[4:0];
      alu_sra:    alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
      alu_or:     alu_out = op_a | op_b;
      alu_and:    alu_out = op_a & op_b;
      alu_pass_b: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  // sub gives equality, slt/sltu give less-than in bit 0
  assign cond  = (ctrl.alu_op == alu_sub) ? alu_out == '0 : alu_out[0];
  assign taken = ctrl.is_branch && (cond ^ ctrl.load_unsigned);

  assign pc_plus4 = pc + word_t'(4);
  assign mem_addr = rs1_data + imm;
  assign result   = (ctrl.is_jal || ctrl.is_jalr) ? pc_plus4 : alu_out;

  assign next_pc = ctrl.is_jalr ? {mem_addr[xlen-1:1], 1'b0} :
                   (ctrl.is_jal || taken) ? pc + imm : pc_plus4;
endmodule

// ==== logic/load_store_unit.sv ====
module load_store_unit (
  input  logic           clk,
  input  rv_pkg::phase_e phase,
  input  rv_pkg::ctrl_t  ctrl,
  input  rv_pkg::word_t  mem_addr,
  input  rv_pkg::word_t  store_data,
  input  rv_pkg::word_t  exec_result,
  output rv_pkg::word_t  rd_data,
  output logic           rd_we,
  dmem_if.lsu            dmem
);
  import rv_pkg::*;

  logic       in_exec;
  logic [1:0] ld_off;
  logic [1:0] ld_size;
  word_t      shifted;
  word_t      load_val;
  logic [3:0] size_mask;

  assign in_exec = phase == ph_exec;

  assign dmem.addr = {2'b00, mem_addr[xlen-1:2]};
  assign dmem.re   = in_exec && ctrl.is_load;

  // byte lanes replicated so every offset sees its data
  assign dmem.wdata = (ctrl.mem_size == 2'd0) ? {4{store_data[7:0]}} :
                      (ctrl.mem_size == 2'd1) ? {2{store_data[15:0]}} : store_data;
  assign size_mask  = (ctrl.mem_size == 2'd0) ? 4'b0001 :
                      (ctrl.mem_size == 2'd1) ? 4'b0011 : 4'b1111;
  assign dmem.be    = (in_exec && ctrl.is_store) ? size_mask << mem_addr[1:0] : 4'b0000;

  // rdata arrives in the load phase, keep where to find it
  always_ff @(posedge clk) begin
    if (in_exec) begin
      ld_off  <= mem_addr[1:0];
      ld_size <= ctrl.mem_size;
    end
  end

  assign shifted = dmem.rdata >> {ld_off, 3'b000};

  always_comb begin
    case (ld_size)
      2'd0:    load_val = {{24{shifted[7] && !ctrl.load_unsigned}}, shifted[7:0]};
      2'd1:    load_val = {{16{shifted[15] && !ctrl.load_unsigned}}, shifted[15:0]};
      default: load_val = shifted;
    endcase
  end

  assign rd_data = (phase == ph_load) ? load_val : exec_result;
  assign rd_we   = ctrl.reg_we && ((in_exec && !ctrl.is_load) || phase == ph_load);

  mem_aligned_a: assert property (@(posedge clk)
    (in_exec && (ctrl.is_load || ctrl.is_store)) |->
      (ctrl.mem_size == 2'd0 || (ctrl.mem_size == 2'd1 && !mem_addr[0]) ||
       mem_addr[1:0] == 2'b00));
endmodule

// ==== logic/data_ram.sv ====
module data_ram #(
  parameter int dmem_words = 256
) (
  input logic clk,
  dmem_if.ram dmem
);
  import rv_pkg::*;

  localparam int daw = $clog2(dmem_words);

  word_t          mem [dmem_words] = '{default: '0};
  logic [daw-1:0] idx;

  assign idx = dmem.addr[daw-1:0];

  always_ff @(posedge clk) begin
    // read-first, a same-edge store is not seen
    if (dmem.re) begin
      dmem.rdata <= mem[idx];
    end
    for (int b = 0; b < 4; b++) begin
      if (dmem.be[b]) begin
        mem[idx][8*b +: 8] <= dmem.wdata[8*b +: 8];
      end
    end
  end
endmodule

// ==== logic/rv_core.sv ====
module rv_core #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             prog_we,
  input  rv_pkg::word_t    prog_addr,
  input  rv_pkg::word_t    prog_data,
  output logic             retire,
  output rv_pkg::word_t    retire_pc,
  output logic             rd_we,
  output rv_pkg::reg_idx_t rd_addr,
  output rv_pkg::word_t    rd_data,
  output logic             halt
);
  import rv_pkg::*;

  word_t    pc;
  insn_u    insn;
  phase_e   phase;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm;
  ctrl_t    ctrl;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    result;
  word_t    next_pc;
  word_t    mem_addr;

  dmem_if u_dmem ();

  assign retire_pc = pc;

  fetch_seq #(
    .imem_words(imem_words)
  ) u_fetch (
    .clk      (clk),
    .rst      (rst),
    .prog_we  (prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .next_pc  (next_pc),
    .is_load  (ctrl.is_load),
    .is_halt  (ctrl.is_halt),
    .pc       (pc),
    .insn     (insn),
    .phase    (phase),
    .retire   (retire),
    .halt     (halt)
  );

  decoder u_decoder (
    .insn(insn),
    .rs1 (rs1),
    .rs2 (rs2),
    .rd  (rd_addr),
    .imm (imm),
    .ctrl(ctrl)
  );

  reg_file u_regs (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd_addr),
    .we      (rd_we),
    .rd_data (rd_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  exec_unit u_exec (
    .pc      (pc),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .imm     (imm),
    .ctrl    (ctrl),
    .result  (result),
    .next_pc (next_pc),
    .mem_addr(mem_addr)
  );

  // write-back mux lives in the lsu
  load_store_unit u_lsu (
    .clk        (clk),
    .phase      (phase),
    .ctrl       (ctrl),
    .mem_addr   (mem_addr),
    .store_data (rs2_data),
    .exec_result(result),
    .rd_data    (rd_data),
    .rd_we      (rd_we),
    .dmem       (u_dmem.lsu)
  );

  data_ram #(
    .dmem_words(dmem_words)
  ) u_dram (
    .clk (clk),
    .dmem(u_dmem.ram)
  );
endmodule

// ==== verif/tb_rv_core.sv ====
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ns;
  import rv_pkg::*;

  localparam int n_progs    = 20;
  localparam int n_body     = 48;
  localparam int n_words    = n_body + 1;
  localparam int rst_cycles = 10;
  localparam int dmem_bytes = 1024;
  // program load, reset, every insn a load, halt watch, a little slack
  localparam int prog_cycles = n_words + rst_cycles + 3 * n_words + 10 + 4;
  localparam int limit_ns    = 2 * n_progs * prog_cycles * 20;

  localparam int k_opimm  = 0;
  localparam int k_op     = 1;
  localparam int k_lui    = 2;
  localparam int k_auipc  = 3;
  localparam int k_load   = 4;
  localparam int k_store  = 5;
  localparam int k_branch = 6;
  localparam int k_jal    = 7;
  localparam int k_jalr   = 8;
  localparam int k_ecall  = 9;

  logic     clk;
  logic     rst;
  logic     prog_we;
  word_t    prog_addr;
  word_t    prog_data;
  logic     retire;
  word_t    retire_pc;
  logic     rd_we;
  reg_idx_t rd_addr;
  word_t    rd_data;
  logic     halt;

  integer seed;

  // program words plus the fields the model runs from
  word_t      prog  [n_words];
  int         kind  [n_words];
  logic [2:0] f3    [n_words];
  logic       alt   [n_words];
  reg_idx_t   f_rd  [n_words];
  reg_idx_t   f_rs1 [n_words];
  reg_idx_t   f_rs2 [n_words];
  word_t      f_imm [n_words];

  // reference model state whose dmem survives a reset like the RAM
  word_t      m_pc;
  word_t      m_regs [32];
  logic [7:0] m_mem  [dmem_bytes];

  rv_core u_dut (
    .clk      (clk),
    .rst      (rst),
    .prog_we  (prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .retire   (retire),
    .retire_pc(retire_pc),
    .rd_we    (rd_we),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .halt     (halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  initial begin
    #(limit_ns);
    report_failure("processor did not halt in time");
  end

  function automatic int unsigned pick(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic word_t r_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f, reg_idx_t rd);
    return {f7, rs2, rs1, f, rd, 7'h33};
  endfunction

  function automatic word_t i_word(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f,
                                   reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f, rd, op};
  endfunction

  function automatic word_t s_word(word_t imm, reg_idx_t rs2, logic [2:0] f);
    return {imm[11:5], rs2, 5'd0, f, imm[4:0], 7'h23};
  endfunction

  function automatic word_t b_word(word_t imm, reg_idx_t rs2, reg_idx_t rs1, logic [2:0] f);
    return {imm[12], imm[10:5], rs2, rs1, f, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t j_word(word_t imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // rv32i integer semantics where alt picks sub or sra
  function automatic word_t alu_model(logic [2:0] f, logic alt_op, word_t a, word_t b);
    case (f)
      3'd0:    return alt_op ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt_op ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic make_program();
    int unsigned sel;
    int unsigned tgt;
    int unsigned span;
    word_t       r;
    for (int i = 0; i < n_body; i++) begin
      sel      = pick(20);
      f_rd[i]  = reg_idx_t'(pick(32));
      f_rs1[i] = reg_idx_t'(pick(32));
      f_rs2[i] = reg_idx_t'(pick(32));
      alt[i]   = 1'b0;
      f3[i]    = 3'd0;
      span     = (n_words - 1 - i < 8) ? n_words - 1 - i : 8;
      tgt      = i + 1 + pick(span);
      r        = word_t'(pick(32'h0010_0000));
      if (sel < 5) begin
        kind[i] = k_opimm;
        f3[i]   = 3'(pick(8));
        if (f3[i] == 3'd1 || f3[i] == 3'd5) begin
          alt[i]   = (f3[i] == 3'd5) ? 1'(pick(2)) : 1'b0;
          f_imm[i] = word_t'(r[4:0]);
        end else begin
          f_imm[i] = {{20{r[11]}}, r[11:0]};
        end
        prog[i] = i_word(f_imm[i][11:0] | (alt[i] ? 12'h400 : 12'h000), f_rs1[i], f3[i],
                         f_rd[i], 7'h13);
      end else if (sel < 9) begin
        kind[i] = k_op;
        f3[i]   = 3'(pick(8));
        alt[i]  = (f3[i] == 3'd0 || f3[i] == 3'd5) ? 1'(pick(2)) : 1'b0;
        prog[i] = r_word(alt[i] ? 7'h20 : 7'h00, f_rs2[i], f_rs1[i], f3[i], f_rd[i]);
      end else if (sel < 11) begin
        kind[i]  = (sel == 9) ? k_lui : k_auipc;
        f_imm[i] = {r[19:0], 12'h000};
        prog[i]  = {r[19:0], f_rd[i], (sel == 9) ? 7'h37 : 7'h17};
      end else if (sel < 17) begin
        // base x0 with an offset aligned to the access size
        f_rs1[i] = '0;
        sel      = pick(5);
        if (pick(2) == 0) begin
          kind[i] = k_load;
          f3[i]   = (sel < 3) ? 3'(sel) : 3'(sel + 1);
        end else begin
          kind[i] = k_store;
          f3[i]   = 3'(sel % 3);
        end
        f_imm[i] = word_t'(pick(dmem_bytes >> f3[i][1:0]) << f3[i][1:0]);
        if (kind[i] == k_load) begin
          prog[i] = i_word(f_imm[i][11:0], 5'd0, f3[i], f_rd[i], 7'h03);
        end else begin
          prog[i] = s_word(f_imm[i], f_rs2[i], f3[i]);
        end
      end else if (sel < 19) begin
        kind[i]  = k_branch;
        sel      = pick(6);
        f3[i]    = (sel < 2) ? 3'(sel) : 3'(sel + 2);
        f_imm[i] = word_t'((tgt - i) * 4);
        prog[i]  = b_word(f_imm[i], f_rs2[i], f_rs1[i], f3[i]);
      end else if (pick(2) == 0) begin
        kind[i]  = k_jal;
        f_imm[i] = word_t'((tgt - i) * 4);
        prog[i]  = j_word(f_imm[i], f_rd[i]);
      end else begin
        kind[i]  = k_jalr;
        f_rs1[i] = '0;
        f_imm[i] = word_t'(tgt * 4);
        prog[i]  = i_word(f_imm[i][11:0], 5'd0, 3'd0, f_rd[i], 7'h67);
      end
    end
    kind[n_body] = k_ecall;
    prog[n_body] = 32'h0000_0073;
  endtask

  task automatic model_step(output logic we, output reg_idx_t rd, output word_t val,
                            output logic is_ld, output logic is_ecall);
    int    i;
    word_t a;
    word_t b;
    word_t addr;
    word_t nxt;
    logic  take;
    i        = int'(m_pc[31:2]);
    a        = m_regs[f_rs1[i]];
    b        = m_regs[f_rs2[i]];
    addr     = a + f_imm[i];
    nxt      = m_pc + 32'd4;
    rd       = f_rd[i];
    we       = 1'b1;
    val      = '0;
    is_ld    = 1'b0;
    is_ecall = 1'b0;
    case (kind[i])
      k_opimm: val = alu_model(f3[i], alt[i], a, f_imm[i]);
      k_op:    val = alu_model(f3[i], alt[i], a, b);
      k_lui:   val = f_imm[i];
      k_auipc: val = m_pc + f_imm[i];
      k_load: begin
        is_ld = 1'b1;
        case (f3[i][1:0])
          2'd0: val = {{24{m_mem[addr][7] && !f3[i][2]}}, m_mem[addr]};
          2'd1: val = {{16{m_mem[addr+1][7] && !f3[i][2]}}, m_mem[addr+1], m_mem[addr]};
          default: val = {m_mem[addr+3], m_mem[addr+2], m_mem[addr+1], m_mem[addr]};
        endcase
      end
      k_store: begin
        we = 1'b0;
        for (int k = 0; k < (1 << f3[i][1:0]); k++) begin
          m_mem[addr+k] = b[8*k +: 8];
        end
      end
      k_branch: begin
        we = 1'b0;
        case (f3[i])
          3'd0:    take = a == b;
          3'd1:    take = a != b;
          3'd4:    take = $signed(a) < $signed(b);
          3'd5:    take = $signed(a) >= $signed(b);
          3'd6:    take = a < b;
          default: take = a >= b;
        endcase
        if (take) begin
          nxt = m_pc + f_imm[i];
        end
      end
      k_jal: begin
        val = m_pc + 32'd4;
        nxt = m_pc + f_imm[i];
      end
      k_jalr: begin
        val = m_pc + 32'd4;
        nxt = addr & ~32'd1;
      end
      default: begin
        we       = 1'b0;
        is_ecall = 1'b1;
      end
    endcase
    if (we && rd != '0) begin
      m_regs[rd] = val;
    end
    m_pc = nxt;
  endtask

  task automatic check_pc(word_t exp);
    if (retire_pc !== exp) begin
      report_failure($sformatf("mismatch at %0t: retire_pc %h, model expects %h",
                               $time, retire_pc, exp));
    end
  endtask

  task automatic check_reg_write(reg_idx_t exp_rd, word_t exp_data);
    if (rd_addr !== exp_rd || rd_data !== exp_data) begin
      report_failure($sformatf("mismatch at %0t: write x%0d = %h, model expects x%0d = %h",
                               $time, rd_addr, rd_data, exp_rd, exp_data));
    end
  endtask

  task automatic check_write_enable(logic exp);
    if (rd_we !== exp) begin
      report_failure($sformatf("mismatch at %0t: rd_we %b at pc %h, model expects %b",
                               $time, rd_we, retire_pc, exp));
    end
  endtask

  task automatic check_halt(logic exp);
    if (halt !== exp) begin
      report_failure($sformatf("mismatch at %0t: halt %b, model expects %b",
                               $time, halt, exp));
    end
  endtask

  task automatic check_gap(int got, int exp);
    if (got != exp) begin
      report_failure($sformatf("mismatch at %0t: retire after %0d cycles, expected %0d",
                               $time, got, exp));
    end
  endtask

  // count cycles up to the next retire strobe
  task automatic wait_retire(int exp_gap);
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (!retire) begin
        check_halt(1'b0);
        if (cnt >= exp_gap) begin
          report_failure($sformatf("no retire strobe within %0d cycles at %0t",
                                   exp_gap, $time));
        end
      end
    end while (!retire);
    check_gap(cnt, exp_gap);
  endtask

  task automatic run_program();
    logic     exp_we;
    reg_idx_t exp_rd;
    word_t    exp_val;
    logic     exp_ld;
    logic     exp_halt;
    word_t    exp_pc;
    make_program();
    @(posedge clk);
    rst <= 1'b1;
    for (int w = 0; w < n_words; w++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= word_t'(w);
      prog_data <= prog[w];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    // reset stays up another 10 cycles past the load
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
    m_pc = '0;
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    exp_halt = 1'b0;
    while (!exp_halt) begin
      exp_pc = m_pc;
      model_step(exp_we, exp_rd, exp_val, exp_ld, exp_halt);
      wait_retire(exp_ld ? 3 : 2);
      check_pc(exp_pc);
      check_write_enable(exp_we);
      if (exp_we) begin
        check_reg_write(exp_rd, exp_val);
      end
      check_halt(1'b0);
    end
    // the core must stay quiet once ecall has retired
    repeat (10) begin
      @(negedge clk);
      check_halt(1'b1);
      if (retire) begin
        report_failure("retire strobe seen after the core halted");
      end
    end
  endtask

  initial begin
    seed      = 32'h08b4_0306;
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    for (int b = 0; b < dmem_bytes; b++) begin
      m_mem[b] = 8'h00;
    end
    for (int p = 0; p < n_progs; p++) begin
      run_program();
    end
    $display("Everything OK");
    $finish;
  end
endmodule

// ==== sources.f ====
logic/rv_pkg.sv
logic/dmem_if.sv
logic/reg_file.sv
logic/fetch_seq.sv
logic/decoder.sv
logic/exec_unit.sv
logic/load_store_unit.sv
logic/data_ram.sv
logic/rv_core.sv
verif/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/dmem_if.sv
  - logic/reg_file.sv
  - logic/fetch_seq.sv
  - logic/decoder.sv
  - logic/exec_unit.sv
  - logic/load_store_unit.sv
  - logic/data_ram.sv
  - logic/rv_core.sv
  - target: simulation
    files:
      - verif/tb_rv_core.sv
